// File: source/dataCache_settings.svh
`ifndef DATACACHE_SETTINGS_SVH
`define DATACACHE_SETTINGS_SVH

// data and address width
`define WORD_WIDTH 32

// 8 sets of one word each
`define SET_INDEX_WIDTH 3

// 256 words of backing memory
`define MEM_ADDR_WIDTH 8

`endif

// File: source/cachePkg.sv
`include "dataCache_settings.svh"

package cachePkg;

    localparam int TAG_WIDTH = `WORD_WIDTH - `SET_INDEX_WIDTH - 2;
    localparam int BYTE_COUNT = `WORD_WIDTH / 8;

    typedef logic [`WORD_WIDTH-1:0] cacheWord_t;

    // memory sees a flat word, the cache sees tag, set and offset
    typedef union packed {
        cacheWord_t raw;
        struct packed {
            logic [TAG_WIDTH-1:0] tag;
            logic [`SET_INDEX_WIDTH-1:0] set;
            logic [1:0] offset;
        } fields;
    } cacheAddr_u;

    typedef struct packed {
        logic write;
        cacheAddr_u addr;
        cacheWord_t writeData;
        logic [BYTE_COUNT-1:0] byteEnable;
    } cacheReq_t;

    typedef struct packed {
        cacheWord_t readData;
        logic hit;
    } cacheResp_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        logic [TAG_WIDTH-1:0] tag;
    } tagEntry_t;

    typedef struct packed {
        logic write;
        logic [`MEM_ADDR_WIDTH-1:0] addr;
        cacheWord_t data;
    } memReq_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        FILL,
        RESPOND
    } ctrlState_e;

endpackage

// File: source/tagStore.sv
`include "dataCache_settings.svh"

module tagStore (
    input  logic CLK,
    input  logic reset,
    input  logic [`SET_INDEX_WIDTH-1:0] lookupSet,
    input  logic updateValid,
    input  logic [`SET_INDEX_WIDTH-1:0] updateSet,
    input  cachePkg::tagEntry_t updateEntry,
    output cachePkg::tagEntry_t lookupEntry
);

    import cachePkg::*;

    localparam int SET_COUNT = 2 ** `SET_INDEX_WIDTH;

    tagEntry_t entries [SET_COUNT];

    // every set starts invalid and clean
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < SET_COUNT; i++) begin
                entries[i].valid <= 1'b0;
                entries[i].dirty <= 1'b0;
            end
        end else if (updateValid) begin
            entries[updateSet] <= updateEntry;
        end
    end

    // registered lookup, one cycle after lookupSet
    always_ff @(posedge CLK) begin
        lookupEntry <= entries[lookupSet];
    end

    // a dirty line must always be a valid line
    assert property (@(posedge CLK) disable iff (reset)
        (updateValid && updateEntry.dirty) |-> updateEntry.valid)
    else
        $error("tagStore: dirty entry written without valid bit, set %0d", updateSet);

endmodule

// File: source/dataStore.sv
`include "dataCache_settings.svh"

module dataStore (
    input  logic CLK,
    input  logic [`SET_INDEX_WIDTH-1:0] readSet,
    input  logic writeValid,
    input  logic [`SET_INDEX_WIDTH-1:0] writeSet,
    input  cachePkg::cacheWord_t writeData,
    input  logic [cachePkg::BYTE_COUNT-1:0] writeByteEnable,
    output cachePkg::cacheWord_t readData
);

    import cachePkg::*;

    localparam int SET_COUNT = 2 ** `SET_INDEX_WIDTH;

    cacheWord_t words [SET_COUNT];

    // byte lanes written independently
    always_ff @(posedge CLK) begin
        if (writeValid) begin
            for (int b = 0; b < BYTE_COUNT; b++) begin
                if (writeByteEnable[b]) begin
                    words[writeSet][b*8 +: 8] <= writeData[b*8 +: 8];
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        readData <= words[readSet];
    end

    // controller never issues an empty write
    assert property (@(posedge CLK)
        writeValid |-> (writeByteEnable != '0))
    else
        $error("dataStore: write to set %0d with no byte enables", writeSet);

endmodule

// File: source/cacheController.sv
`include "dataCache_settings.svh"

module cacheController (
    input  logic CLK,
    input  logic reset,
    input  logic reqValid,
    input  cachePkg::cacheReq_t req,
    input  cachePkg::tagEntry_t lookupEntry,
    input  cachePkg::cacheWord_t storedData,
    input  cachePkg::cacheWord_t memReadData,
    output logic respValid,
    output cachePkg::cacheResp_t resp,
    output logic [`SET_INDEX_WIDTH-1:0] lookupSet,
    output logic tagUpdateValid,
    output logic [`SET_INDEX_WIDTH-1:0] tagUpdateSet,
    output cachePkg::tagEntry_t tagUpdateEntry,
    output logic [`SET_INDEX_WIDTH-1:0] dataReadSet,
    output logic dataWriteValid,
    output logic [`SET_INDEX_WIDTH-1:0] dataWriteSet,
    output cachePkg::cacheWord_t dataWriteData,
    output logic [cachePkg::BYTE_COUNT-1:0] dataWriteByteEnable,
    output logic memValid,
    output cachePkg::memReq_t memReq
);

    import cachePkg::*;

    ctrlState_e state;
    ctrlState_e nextState;
    cacheReq_t reqReg;
    logic fillReady;
    logic lookupHit;
    logic victimDirty;
    cacheAddr_u victimAddr;
    cacheWord_t hitWord;
    cacheWord_t fillWord;

    function automatic cacheWord_t mergeBytes(input cacheWord_t base, input cacheWord_t update,
                                              input logic [BYTE_COUNT-1:0] enable);
        cacheWord_t merged;
        merged = base;
        for (int b = 0; b < BYTE_COUNT; b++) begin
            if (enable[b]) begin
                merged[b*8 +: 8] = update[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign lookupHit = lookupEntry.valid && (lookupEntry.tag == reqReg.addr.fields.tag);
    assign victimDirty = lookupEntry.valid && lookupEntry.dirty;
    assign hitWord = reqReg.write ?
        mergeBytes(storedData, reqReg.writeData, reqReg.byteEnable) : storedData;
    assign fillWord = reqReg.write ?
        mergeBytes(memReadData, reqReg.writeData, reqReg.byteEnable) : memReadData;

    // stores are read at the strobe edge, then held on the captured set
    assign lookupSet = (state == IDLE) ? req.addr.fields.set : reqReg.addr.fields.set;
    assign dataReadSet = lookupSet;
    assign respValid = (state == RESPOND);

    always_comb begin
        victimAddr.fields.tag = lookupEntry.tag;
        victimAddr.fields.set = reqReg.addr.fields.set;
        victimAddr.fields.offset = 2'b00;

        nextState = state;
        tagUpdateValid = 1'b0;
        tagUpdateSet = reqReg.addr.fields.set;
        tagUpdateEntry.valid = 1'b1;
        tagUpdateEntry.dirty = reqReg.write;
        tagUpdateEntry.tag = reqReg.addr.fields.tag;
        dataWriteValid = 1'b0;
        dataWriteSet = reqReg.addr.fields.set;
        dataWriteData = reqReg.writeData;
        dataWriteByteEnable = reqReg.byteEnable;
        memValid = 1'b0;
        memReq.write = 1'b0;
        memReq.addr = reqReg.addr.raw[`MEM_ADDR_WIDTH+1:2];
        memReq.data = storedData;

        case (state)
            IDLE: begin
                if (reqValid) begin
                    nextState = LOOKUP;
                end
            end
            LOOKUP: begin
                if (lookupHit) begin
                    // write hit merges in place and marks the line dirty
                    tagUpdateValid = reqReg.write;
                    dataWriteValid = reqReg.write;
                    nextState = RESPOND;
                end else if (victimDirty) begin
                    nextState = WRITEBACK;
                end else begin
                    nextState = FILL;
                end
            end
            WRITEBACK: begin
                memValid = 1'b1;
                memReq.write = 1'b1;
                memReq.addr = victimAddr.raw[`MEM_ADDR_WIDTH+1:2];
                nextState = FILL;
            end
            FILL: begin
                if (!fillReady) begin
                    memValid = 1'b1;
                end else begin
                    // fill word arrives, install line with merged bytes
                    tagUpdateValid = 1'b1;
                    dataWriteValid = 1'b1;
                    dataWriteData = fillWord;
                    dataWriteByteEnable = '1;
                    nextState = RESPOND;
                end
            end
            RESPOND: begin
                nextState = IDLE;
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            state <= IDLE;
            fillReady <= 1'b0;
        end else begin
            state <= nextState;
            fillReady <= (state == FILL) && !fillReady;
        end
    end

    always_ff @(posedge CLK) begin
        if (state == IDLE && reqValid) begin
            reqReg <= req;
        end
        if (state == LOOKUP) begin
            resp.hit <= lookupHit;
            resp.readData <= hitWord;
        end
        if (state == FILL && fillReady) begin
            resp.readData <= fillWord;
        end
    end

    // one request in flight, next strobe only after respValid
    assert property (@(posedge CLK) disable iff (reset)
        reqValid |-> (state == IDLE))
    else
        $error("cacheController: request strobe while busy in state %s", state.name());

    assert property (@(posedge CLK) disable iff (reset)
        reqValid |-> (req.addr.raw[`WORD_WIDTH-1:`MEM_ADDR_WIDTH+2] == '0))
    else
        $error("cacheController: address %h beyond backing memory", req.addr.raw);

endmodule

// File: source/backingMemory.sv
`include "dataCache_settings.svh"

module backingMemory (
    input  logic CLK,
    input  logic reset,
    input  logic memValid,
    input  cachePkg::memReq_t memReq,
    output cachePkg::cacheWord_t memReadData
);

    import cachePkg::*;

    localparam int DEPTH = 2 ** `MEM_ADDR_WIDTH;

    cacheWord_t words [DEPTH];

    // every byte of word i holds i
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int i = 0; i < DEPTH; i++) begin
                words[i] <= cacheWord_t'(i) * cacheWord_t'(32'h0101_0101);
            end
        end else if (memValid && memReq.write) begin
            words[memReq.addr] <= memReq.data;
        end
    end

    // read data valid the cycle after the strobe
    always_ff @(posedge CLK) begin
        if (memValid && !memReq.write) begin
            memReadData <= words[memReq.addr];
        end
    end

endmodule

// File: source/dataCacheTop.sv
`include "dataCache_settings.svh"

module dataCacheTop (
    input  logic CLK,
    input  logic reset,
    input  logic reqValid,
    input  cachePkg::cacheReq_t req,
    output logic respValid,
    output cachePkg::cacheResp_t resp
);

    import cachePkg::*;

    logic [`SET_INDEX_WIDTH-1:0] lookupSet;
    logic [`SET_INDEX_WIDTH-1:0] tagUpdateSet;
    logic [`SET_INDEX_WIDTH-1:0] dataReadSet;
    logic [`SET_INDEX_WIDTH-1:0] dataWriteSet;
    logic tagUpdateValid;
    logic dataWriteValid;
    logic memValid;
    logic [BYTE_COUNT-1:0] dataWriteByteEnable;
    tagEntry_t lookupEntry;
    tagEntry_t tagUpdateEntry;
    cacheWord_t storedData;
    cacheWord_t dataWriteData;
    cacheWord_t memReadData;
    memReq_t memReq;

    cacheController controller (
        .CLK(CLK),
        .reset(reset),
        .reqValid(reqValid),
        .req(req),
        .lookupEntry(lookupEntry),
        .storedData(storedData),
        .memReadData(memReadData),
        .respValid(respValid),
        .resp(resp),
        .lookupSet(lookupSet),
        .tagUpdateValid(tagUpdateValid),
        .tagUpdateSet(tagUpdateSet),
        .tagUpdateEntry(tagUpdateEntry),
        .dataReadSet(dataReadSet),
        .dataWriteValid(dataWriteValid),
        .dataWriteSet(dataWriteSet),
        .dataWriteData(dataWriteData),
        .dataWriteByteEnable(dataWriteByteEnable),
        .memValid(memValid),
        .memReq(memReq)
    );

    tagStore tags (
        .CLK(CLK),
        .reset(reset),
        .lookupSet(lookupSet),
        .updateValid(tagUpdateValid),
        .updateSet(tagUpdateSet),
        .updateEntry(tagUpdateEntry),
        .lookupEntry(lookupEntry)
    );

    dataStore data (
        .CLK(CLK),
        .readSet(dataReadSet),
        .writeValid(dataWriteValid),
        .writeSet(dataWriteSet),
        .writeData(dataWriteData),
        .writeByteEnable(dataWriteByteEnable),
        .readData(storedData)
    );

    // memory sits beside the cache, not behind a bus
    backingMemory memory (
        .CLK(CLK),
        .reset(reset),
        .memValid(memValid),
        .memReq(memReq),
        .memReadData(memReadData)
    );

endmodule

// File: verification/dataCacheTb.sv
module dataCacheTb;

    import cachePkg::*;

    // one trace line, the request and what the cache must answer
    typedef struct packed {
        cacheReq_t req;
        cacheResp_t expected;
    } traceEntry_t;

    localparam string TRACE_PATH = "verification/dataCache_trace.txt";

    logic CLK;
    logic reset;
    logic reqValid;
    cacheReq_t req;
    logic respValid;
    cacheResp_t resp;

    traceEntry_t trace [$];
    bit traceLoaded;
    int timeoutLimit;
    int cycleCount;

    dataCacheTop DUT (
        .CLK(CLK),
        .reset(reset),
        .reqValid(reqValid),
        .req(req),
        .respValid(respValid),
        .resp(resp)
    );

    initial begin
        CLK = 1'b0;
        forever begin
            #5 CLK = ~CLK;
        end
    end

    task automatic loadTrace();
        int fd;
        int fields;
        string line;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] writeData;
        logic [31:0] byteEnable;
        logic [31:0] expData;
        logic [31:0] expHit;
        traceEntry_t entry;
        fd = $fopen(TRACE_PATH, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", TRACE_PATH);
            $display("STATUS: FAIL");
            $fatal(1, "trace file missing");
        end else begin
            while ($fgets(line, fd) > 0) begin
                // skip comment lines, keep full six-column lines
                if (line.len() > 0 && line[0] != "#") begin
                    fields = $sscanf(line, "%h %h %h %h %h %h",
                                     op, addr, writeData, byteEnable, expData, expHit);
                    if (fields == 6) begin
                        entry.req.write = op[0];
                        entry.req.addr.raw = addr;
                        entry.req.writeData = writeData;
                        entry.req.byteEnable = byteEnable[BYTE_COUNT-1:0];
                        entry.expected.readData = expData;
                        entry.expected.hit = expHit[0];
                        trace.push_back(entry);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic checkReadData(input cacheWord_t actual, input cacheWord_t expected,
                                 input int index);
        if (actual !== expected) begin
            $display("[ERROR] %0t: request %0d returned readData %h, expected %h",
                     $time, index, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "readData mismatch");
        end
    endtask

    task automatic checkHit(input logic actual, input logic expected, input int index);
        if (actual !== expected) begin
            $display("[ERROR] %0t: request %0d returned hit %b, expected %b",
                     $time, index, actual, expected);
            $display("STATUS: FAIL");
            $fatal(1, "hit flag mismatch");
        end
    endtask

    task automatic checkRespValid(input logic actual, input logic expected, input int index);
        if (actual !== expected) begin
            $display("[ERROR] %0t: respValid %b before request %0d, expected %b",
                     $time, actual, index, expected);
            $display("STATUS: FAIL");
            $fatal(1, "respValid mismatch");
        end
    endtask

    // strobe one cycle, then wait for the response strobe
    task automatic runRequest(input traceEntry_t entry, input int index);
        @(posedge CLK);
        #1;
        // previous response strobe lasts a single cycle
        checkRespValid(respValid, 1'b0, index);
        reqValid = 1'b1;
        req = entry.req;
        @(posedge CLK);
        #1;
        reqValid = 1'b0;
        req = '0;
        while (!respValid) begin
            @(posedge CLK);
            #1;
        end
        checkReadData(resp.readData, entry.expected.readData, index);
        checkHit(resp.hit, entry.expected.hit, index);
    endtask

    initial begin
        wait (traceLoaded);
        forever begin
            @(posedge CLK);
            cycleCount++;
            if (cycleCount > timeoutLimit) begin
                $display("timeout after %0d cycles, controller stuck in state %s",
                         cycleCount, DUT.controller.state.name());
                $display("STATUS: FAIL");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        reset = 1'b1;
        reqValid = 1'b0;
        req = '0;
        cycleCount = 0;
        loadTrace();
        // worst case miss is well under 8 cycles per request
        timeoutLimit = trace.size() * 8 + 20;
        traceLoaded = 1'b1;
        repeat (3) @(posedge CLK);
        #1 reset = 1'b0;
        foreach (trace[i]) begin
            runRequest(trace[i], i);
        end
        if (trace.size() > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("trace held no requests");
            $display("STATUS: FAIL");
            $fatal(1, "empty trace");
        end
    end

endmodule

// File: src.f
+incdir+source
source/cachePkg.sv
source/tagStore.sv
source/dataStore.sv
source/cacheController.sv
source/backingMemory.sv
source/dataCacheTop.sv
verification/dataCacheTb.sv

// File: Makefile
VERILATOR ?= verilator
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS ?= --binary --timing --assert -j 0
TOP := dataCacheTb
FILELIST := src.f
OBJDIR := obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: verification/dataCache_trace.txt
# op (0 read, 1 write) address writeData byteEnable expectedReadData expectedHit
# all columns hex, memory word i resets to i * 01010101
0 00000004 00000000 0 01010101 0
0 00000004 00000000 0 01010101 1
1 00000004 AABBCCDD 3 0101CCDD 1
0 00000004 00000000 0 0101CCDD 1
1 00000008 11223344 C 11220202 0
0 00000008 00000000 0 11220202 1
0 00000024 00000000 0 09090909 0
0 00000004 00000000 0 0101CCDD 0
0 00000024 00000000 0 09090909 0
0 00000004 00000000 0 0101CCDD 0
1 00000028 DEADBEEF F DEADBEEF 0
0 00000008 00000000 0 11220202 0
0 00000028 00000000 0 DEADBEEF 0
1 00000028 12345678 1 DEADBE78 1
1 00000028 9A000000 8 9AADBE78 1
0 00000028 00000000 0 9AADBE78 1
0 000003FC 00000000 0 FFFFFFFF 0
1 0000001C 00ABCD00 6 07ABCD07 0
0 000003FC 00000000 0 FFFFFFFF 0
0 0000001C 00000000 0 07ABCD07 0
0 000003FC 00000000 0 FFFFFFFF 0
0 0000001C 00000000 0 07ABCD07 0
0 0000001C 00000000 0 07ABCD07 1
0 00000000 00000000 0 00000000 0
1 00000000 55AA55AA F 55AA55AA 1
0 00000020 00000000 0 08080808 0
0 00000000 00000000 0 55AA55AA 0
0 0000000C 00000000 0 03030303 0
0 00000010 00000000 0 04040404 0
0 00000014 00000000 0 05050505 0
0 00000018 00000000 0 06060606 0
0 0000000C 00000000 0 03030303 1
1 00000010 000000EE 1 040404EE 1
0 00000110 00000000 0 44444444 0
0 00000010 00000000 0 040404EE 0
0 00000017 00000000 0 05050505 1
0 000003E0 00000000 0 F8F8F8F8 0
